// File: dv/mips_stimulus.txt
# program: word count (decimal), then one instruction word (hex) per line
# then stall percent, trace count, and trace lines: pc (hex) register (decimal) value (hex)
35
24010005  addiu r1, r0, 5
2402fffd  addiu r2, r0, -3
00221821  addu  r3, r1, r2
00222023  subu  r4, r1, r2
0041282a  slt   r5, r2, r1
3c061234  lui   r6, 0x1234
34c65678  ori   r6, r6, 0x5678
30c70ff0  andi  r7, r6, 0x0ff0
00c74026  xor   r8, r6, r7
00014900  sll   r9, r1, 4
00065202  srl   r10, r6, 8
00c95824  and   r11, r6, r9
ac060010  sw    r6, 16(r0)
8c0c0010  lw    r12, 16(r0)
01816821  addu  r13, r12, r1
24200007  addiu r0, r1, 7
00017021  addu  r14, r0, r1
10210002  beq   r1, r1, 0x50
240f0001  addiu r15, r0, 1
240f0002  addiu r15, r0, 2
14210002  bne   r1, r1, 0x5c
24100003  addiu r16, r0, 3
24110004  addiu r17, r0, 4
16300002  bne   r17, r16, 0x68
24120006  addiu r18, r0, 6
24120007  addiu r18, r0, 7
12300002  beq   r17, r16, 0x74
02309825  or    r19, r17, r16
24150009  addiu r21, r0, 9
ad2d0008  sw    r13, 8(r9)
8d340008  lw    r20, 8(r9)
0295b023  subu  r22, r20, r21
8c180010  lw    r24, 16(r0)
24190002  addiu r25, r0, 2
0319d021  addu  r26, r24, r25
25
26
00000000 1 00000005
00000004 2 fffffffd
00000008 3 00000002
0000000c 4 00000008
00000010 5 00000001
00000014 6 12340000
00000018 6 12345678
0000001c 7 00000670
00000020 8 12345008
00000024 9 00000050
00000028 10 00123456
0000002c 11 00000050
00000034 12 12345678
00000038 13 1234567d
00000040 14 00000005
00000048 15 00000001
00000054 16 00000003
00000058 17 00000004
00000060 18 00000006
0000006c 19 00000007
00000070 21 00000009
00000078 20 1234567d
0000007c 22 12345674
00000080 24 12345678
00000084 25 00000002
00000088 26 1234567a

// File: sim.f
verilog/mips_pkg.sv
verilog/reg_read_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/reg_file.sv
verilog/hazard_unit.sv
verilog/mips_core.sv
dv/mips_core_assert.sv
dv/mips_core_tb.sv

// File: dv/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb import mips_pkg::*; ();
    localparam int    ROM_WORDS     = 256;
    localparam int    RAM_WORDS     = 256;
    localparam int    MAX_TRACE     = 256;
    localparam int    DRAIN_CYCLES  = 8;
    localparam string STIMULUS_FILE = "dv/mips_stimulus.txt";

    logic      clk;
    logic      reset;
    logic      stall;
    addr_t     rom_addr;
    inst_t     rom_data;
    logic      ram_en;
    logic      ram_we;
    addr_t     ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    addr_t     wb_pc;

    inst_t     rom [ROM_WORDS];
    word_t     ram [RAM_WORDS];
    addr_t     trace_pc [MAX_TRACE];
    reg_addr_t trace_reg [MAX_TRACE];
    word_t     trace_val [MAX_TRACE];

    int     prog_len;
    int     stall_pct;
    int     trace_count;
    int     trace_idx;
    int     cycle_count;
    int     timeout_limit;
    int     fd;
    integer seed = 10308;

    mips_core u_mips_core (
        .clk             (clk),
        .reset_i         (reset),
        .stall_i         (stall),
        .rom_addr_o      (rom_addr),
        .rom_data_i      (rom_data),
        .ram_en_o        (ram_en),
        .ram_we_o        (ram_we),
        .ram_addr_o      (ram_addr),
        .ram_wdata_o     (ram_wdata),
        .ram_rdata_i     (ram_rdata),
        .debug_wb_en_o   (wb_en),
        .debug_wb_addr_o (wb_addr),
        .debug_wb_data_o (wb_data),
        .debug_wb_pc_o   (wb_pc)
    );

    always #50 clk = ~clk;

    // fetches past the ROM return nops
    assign rom_data  = (rom_addr < ROM_WORDS * 4) ? rom[rom_addr[9:2]] : '0;

    // unselected RAM returns unknown data
    assign ram_rdata = ram_en ? ram[ram_addr[9:2]] : 'x;

    always @(posedge clk) begin
        if (ram_en && ram_we) begin
            ram[ram_addr[9:2]] <= ram_wdata;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s expected %0d, got %0d",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    // skips blank and comment lines
    task automatic next_record(output string line);
        int n;
        bit found;
        found = 1'b0;
        while (!found && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                found = 1'b1;
            end
        end
        if (!found) begin
            abort_run("the stimulus file ended before all records were read");
        end
    endtask

    task automatic load_stimulus();
        string       line;
        logic [31:0] word;
        addr_t       pc;
        int          reg_num;
        word_t       value;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file");
        end
        next_record(line);
        if ($sscanf(line, "%d", prog_len) != 1 || prog_len > ROM_WORDS) begin
            abort_run("bad program length in the stimulus file");
        end
        for (int i = 0; i < prog_len; i++) begin
            next_record(line);
            if ($sscanf(line, "%h", word) != 1) begin
                abort_run($sformatf("bad instruction word at program index %0d", i));
            end
            rom[i] = word;
        end
        next_record(line);
        if ($sscanf(line, "%d", stall_pct) != 1) begin
            abort_run("bad stall percentage in the stimulus file");
        end
        next_record(line);
        if ($sscanf(line, "%d", trace_count) != 1 || trace_count > MAX_TRACE) begin
            abort_run("bad trace count in the stimulus file");
        end
        for (int i = 0; i < trace_count; i++) begin
            next_record(line);
            if ($sscanf(line, "%h %d %h", pc, reg_num, value) != 3) begin
                abort_run($sformatf("bad trace entry at index %0d", i));
            end
            trace_pc[i]  = pc;
            trace_reg[i] = reg_num[4:0];
            trace_val[i] = value;
        end
        $fclose(fd);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        stall       = 1'b0;
        trace_idx   = 0;
        cycle_count = 0;
        // pattern over the full byte address
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = 32'hc0de_0000 ^ 32'(i * 4);
        end
        load_stimulus();
        timeout_limit = (prog_len * 4 + 20) * 2;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait (trace_idx == trace_count);
        // catch any write-back past the end of the trace
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

    always @(posedge clk) begin
        if (reset) begin
            stall <= 1'b0;
        end else begin
            stall <= ($unsigned($random(seed)) % 32'd100) < 32'(stall_pct);
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset && wb_en) begin
            if (trace_idx >= trace_count) begin
                abort_run($sformatf("unexpected write-back at %0t from pc %h to r%0d",
                                    $time, wb_pc, wb_addr));
            end else begin
                check_addr("debug_wb_pc_o", trace_pc[trace_idx], wb_pc);
                check_reg("debug_wb_addr_o", trace_reg[trace_idx], wb_addr);
                check_word("debug_wb_data_o", trace_val[trace_idx], wb_data);
                trace_idx = trace_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > timeout_limit) begin
                abort_run($sformatf("timeout after %0d cycles with %0d of %0d write-backs seen",
                                    cycle_count, trace_idx, trace_count));
            end
        end
    end
endmodule

// File: dv/mips_core_assert.sv
`timescale 1ns/1ps

module mips_core_assert import mips_pkg::*; (
    input logic      clk,
    input logic      reset_i,
    input logic      stall_i,
    input addr_t     rom_addr_o,
    input logic      ram_en_o,
    input logic      ram_we_o,
    input logic      debug_wb_en_o,
    input reg_addr_t debug_wb_addr_o
);
    // a frozen pipeline neither retires nor stores
    stall_blocks_writes: assert property (
        @(posedge clk) disable iff (reset_i)
        stall_i |-> !debug_wb_en_o && !ram_we_o
    ) else $error("write-back or store seen while stall_i is high");

    write_needs_enable: assert property (
        @(posedge clk) disable iff (reset_i)
        ram_we_o |-> ram_en_o
    ) else $error("ram_we_o high without ram_en_o");

    no_r0_writeback: assert property (
        @(posedge clk) disable iff (reset_i)
        debug_wb_en_o |-> debug_wb_addr_o != '0
    ) else $error("write-back to register 0 reached the debug port");

    // pc frozen across a stalled cycle
    fetch_holds_on_stall: assert property (
        @(posedge clk) disable iff (reset_i)
        stall_i |=> $stable(rom_addr_o)
    ) else $error("rom_addr_o moved during a stall");
endmodule

bind mips_core mips_core_assert u_mips_core_assert (
    .clk             (clk),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .rom_addr_o      (rom_addr_o),
    .ram_en_o        (ram_en_o),
    .ram_we_o        (ram_we_o),
    .debug_wb_en_o   (debug_wb_en_o),
    .debug_wb_addr_o (debug_wb_addr_o)
);

// File: verilog/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      stall_i,
    output addr_t     rom_addr_o,
    input  inst_t     rom_data_i,
    output logic      ram_en_o,
    output logic      ram_we_o,
    output addr_t     ram_addr_o,
    output word_t     ram_wdata_o,
    input  word_t     ram_rdata_i,
    output logic      debug_wb_en_o,
    output reg_addr_t debug_wb_addr_o,
    output word_t     debug_wb_data_o,
    output addr_t     debug_wb_pc_o
);
    inst_t     if_inst;
    addr_t     if_pc;
    logic      branch_taken;
    addr_t     branch_target;
    logic      load_stall;
    alu_op_e   id_alu_op;
    word_t     id_operand_a;
    word_t     id_operand_b;
    word_t     id_store_data;
    shamt_t    id_shamt;
    logic      id_is_load;
    logic      id_is_store;
    logic      id_wr_en;
    reg_addr_t id_wr_addr;
    addr_t     id_pc;
    word_t     ex_result;
    logic      ex_wr_en;
    reg_addr_t ex_wr_addr;
    logic      ex_is_load;
    word_t     mem_result;
    word_t     mem_store_data;
    logic      mem_is_load;
    logic      mem_is_store;
    logic      mem_wr_en;
    reg_addr_t mem_wr_addr;
    addr_t     mem_pc;
    word_t     rf_raw_data [2];

    reg_read_if u_reg_read_if ();

    fetch_stage u_fetch_stage (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .hold_i          (load_stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .rom_addr_o      (rom_addr_o),
        .rom_data_i      (rom_data_i),
        .inst_o          (if_inst),
        .inst_pc_o       (if_pc)
    );

    decode_stage u_decode_stage (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .load_stall_i    (load_stall),
        .inst_i          (if_inst),
        .inst_pc_i       (if_pc),
        .rd              (u_reg_read_if.decode),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .alu_op_o        (id_alu_op),
        .operand_a_o     (id_operand_a),
        .operand_b_o     (id_operand_b),
        .store_data_o    (id_store_data),
        .shamt_o         (id_shamt),
        .is_load_o       (id_is_load),
        .is_store_o      (id_is_store),
        .wr_en_o         (id_wr_en),
        .wr_addr_o       (id_wr_addr),
        .pc_o            (id_pc)
    );

    execute_stage u_execute_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .alu_op_i         (id_alu_op),
        .operand_a_i      (id_operand_a),
        .operand_b_i      (id_operand_b),
        .store_data_i     (id_store_data),
        .shamt_i          (id_shamt),
        .is_load_i        (id_is_load),
        .is_store_i       (id_is_store),
        .wr_en_i          (id_wr_en),
        .wr_addr_i        (id_wr_addr),
        .pc_i             (id_pc),
        .ex_result_o      (ex_result),
        .ex_wr_en_o       (ex_wr_en),
        .ex_wr_addr_o     (ex_wr_addr),
        .ex_is_load_o     (ex_is_load),
        .mem_result_o     (mem_result),
        .mem_store_data_o (mem_store_data),
        .mem_is_load_o    (mem_is_load),
        .mem_is_store_o   (mem_is_store),
        .mem_wr_en_o      (mem_wr_en),
        .mem_wr_addr_o    (mem_wr_addr),
        .mem_pc_o         (mem_pc)
    );

    // write-back results double as the debug port
    memory_stage u_memory_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .mem_result_i     (mem_result),
        .mem_store_data_i (mem_store_data),
        .mem_is_load_i    (mem_is_load),
        .mem_is_store_i   (mem_is_store),
        .mem_wr_en_i      (mem_wr_en),
        .mem_wr_addr_i    (mem_wr_addr),
        .mem_pc_i         (mem_pc),
        .ram_en_o         (ram_en_o),
        .ram_we_o         (ram_we_o),
        .ram_addr_o       (ram_addr_o),
        .ram_wdata_o      (ram_wdata_o),
        .ram_rdata_i      (ram_rdata_i),
        .wb_en_o          (debug_wb_en_o),
        .wb_addr_o        (debug_wb_addr_o),
        .wb_data_o        (debug_wb_data_o),
        .wb_pc_o          (debug_wb_pc_o)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd         (u_reg_read_if.storage),
        .raw_data_o (rf_raw_data),
        .wb_en_i    (debug_wb_en_o),
        .wb_addr_i  (debug_wb_addr_o),
        .wb_data_i  (debug_wb_data_o)
    );

    hazard_unit u_hazard_unit (
        .rd            (u_reg_read_if.bypass),
        .raw_data_i    (rf_raw_data),
        .ex_result_i   (ex_result),
        .ex_wr_en_i    (ex_wr_en),
        .ex_wr_addr_i  (ex_wr_addr),
        .ex_is_load_i  (ex_is_load),
        .mem_result_i  (mem_result),
        .mem_wr_en_i   (mem_wr_en),
        .mem_wr_addr_i (mem_wr_addr),
        .mem_is_load_i (mem_is_load),
        .load_stall_o  (load_stall)
    );
endmodule

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
    reg_read_if.bypass rd,
    input  word_t      raw_data_i [2],
    input  word_t      ex_result_i,
    input  logic       ex_wr_en_i,
    input  reg_addr_t  ex_wr_addr_i,
    input  logic       ex_is_load_i,
    input  word_t      mem_result_i,
    input  logic       mem_wr_en_i,
    input  reg_addr_t  mem_wr_addr_i,
    input  logic       mem_is_load_i,
    output logic       load_stall_o
);
    logic [1:0] ex_hit;
    logic [1:0] mem_hit;

    function automatic logic hit(input logic en, input reg_addr_t addr,
                                 input logic wr_en, input reg_addr_t wr_addr);
        return en && addr != '0 && wr_en && wr_addr == addr;
    endfunction

    assign ex_hit[0]  = hit(rd.en_1, rd.addr_1, ex_wr_en_i, ex_wr_addr_i);
    assign ex_hit[1]  = hit(rd.en_2, rd.addr_2, ex_wr_en_i, ex_wr_addr_i);
    assign mem_hit[0] = hit(rd.en_1, rd.addr_1, mem_wr_en_i, mem_wr_addr_i);
    assign mem_hit[1] = hit(rd.en_2, rd.addr_2, mem_wr_en_i, mem_wr_addr_i);

    // execute first, then memory, then register file
    assign rd.data_1 = ex_hit[0] ? ex_result_i :
                       (mem_hit[0] && !mem_is_load_i) ? mem_result_i : raw_data_i[0];
    assign rd.data_2 = ex_hit[1] ? ex_result_i :
                       (mem_hit[1] && !mem_is_load_i) ? mem_result_i : raw_data_i[1];

    // load data is only usable once it sits in the write-back register
    assign load_stall_o = (ex_is_load_i && |ex_hit) || (mem_is_load_i && |mem_hit);
endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    reg_read_if.storage rd,
    output word_t       raw_data_o [2],
    input  logic        wb_en_i,
    input  reg_addr_t   wb_addr_i,
    input  word_t       wb_data_i
);
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // write-through covers the write-back stage
    function automatic word_t read_port(input logic en, input reg_addr_t addr);
        word_t data;
        data = '0;
        if (en && addr != '0) begin
            data = (wb_en_i && wb_addr_i == addr) ? wb_data_i : regs[addr];
        end
        return data;
    endfunction

    assign raw_data_o[0] = read_port(rd.en_1, rd.addr_1);
    assign raw_data_o[1] = read_port(rd.en_2, rd.addr_2);
endmodule

// File: verilog/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      stall_i,
    input  word_t     mem_result_i,
    input  word_t     mem_store_data_i,
    input  logic      mem_is_load_i,
    input  logic      mem_is_store_i,
    input  logic      mem_wr_en_i,
    input  reg_addr_t mem_wr_addr_i,
    input  addr_t     mem_pc_i,
    output logic      ram_en_o,
    output logic      ram_we_o,
    output addr_t     ram_addr_o,
    output word_t     ram_wdata_o,
    input  word_t     ram_rdata_i,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o,
    output addr_t     wb_pc_o
);
    logic  wb_wr_en_q;
    logic  wb_is_load_q;
    word_t wb_result_q;
    word_t wb_load_q;

    assign ram_en_o    = mem_is_load_i || mem_is_store_i;
    assign ram_we_o    = mem_is_store_i && !stall_i;
    assign ram_addr_o  = mem_result_i;
    assign ram_wdata_o = mem_store_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_wr_en_q   <= 1'b0;
            wb_is_load_q <= 1'b0;
        end else if (!stall_i) begin
            wb_wr_en_q   <= mem_wr_en_i;
            wb_is_load_q <= mem_is_load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_result_q <= mem_result_i;
            wb_load_q   <= ram_rdata_i;
            wb_addr_o   <= mem_wr_addr_i;
            wb_pc_o     <= mem_pc_i;
        end
    end

    // held instruction retires once, r0 never written
    assign wb_en_o   = wb_wr_en_q && !stall_i && (wb_addr_o != '0);
    assign wb_data_o = wb_is_load_q ? wb_load_q : wb_result_q;
endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      stall_i,
    input  alu_op_e   alu_op_i,
    input  word_t     operand_a_i,
    input  word_t     operand_b_i,
    input  word_t     store_data_i,
    input  shamt_t    shamt_i,
    input  logic      is_load_i,
    input  logic      is_store_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  addr_t     pc_i,
    output word_t     ex_result_o,
    output logic      ex_wr_en_o,
    output reg_addr_t ex_wr_addr_o,
    output logic      ex_is_load_o,
    output word_t     mem_result_o,
    output word_t     mem_store_data_o,
    output logic      mem_is_load_o,
    output logic      mem_is_store_o,
    output logic      mem_wr_en_o,
    output reg_addr_t mem_wr_addr_o,
    output addr_t     mem_pc_o
);
    // also the load/store address
    always_comb begin
        case (alu_op_i)
            ALU_ADD: ex_result_o = operand_a_i + operand_b_i;
            ALU_SUB: ex_result_o = operand_a_i - operand_b_i;
            ALU_AND: ex_result_o = operand_a_i & operand_b_i;
            ALU_OR:  ex_result_o = operand_a_i | operand_b_i;
            ALU_XOR: ex_result_o = operand_a_i ^ operand_b_i;
            ALU_SLT: ex_result_o = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
            ALU_SLL: ex_result_o = operand_b_i << shamt_i;
            ALU_SRL: ex_result_o = operand_b_i >> shamt_i;
            ALU_LUI: ex_result_o = operand_b_i;
            default: ex_result_o = '0;
        endcase
    end

    assign ex_wr_en_o   = wr_en_i;
    assign ex_wr_addr_o = wr_addr_i;
    assign ex_is_load_o = is_load_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_is_load_o  <= 1'b0;
            mem_is_store_o <= 1'b0;
            mem_wr_en_o    <= 1'b0;
        end else if (!stall_i) begin
            mem_is_load_o  <= is_load_i;
            mem_is_store_o <= is_store_i;
            mem_wr_en_o    <= wr_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mem_result_o     <= ex_result_o;
            mem_store_data_o <= store_data_i;
            mem_wr_addr_o    <= wr_addr_i;
            mem_pc_o         <= pc_i;
        end
    end
endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stall_i,
    input  logic       load_stall_i,
    input  inst_t      inst_i,
    input  addr_t      inst_pc_i,
    reg_read_if.decode rd,
    output logic       branch_taken_o,
    output addr_t      branch_target_o,
    output alu_op_e    alu_op_o,
    output word_t      operand_a_o,
    output word_t      operand_b_o,
    output word_t      store_data_o,
    output shamt_t     shamt_o,
    output logic       is_load_o,
    output logic       is_store_o,
    output logic       wr_en_o,
    output reg_addr_t  wr_addr_o,
    output addr_t      pc_o
);
    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      imm_sext;
    alu_op_e    alu_op;
    word_t      imm;
    logic       use_imm;
    logic       is_load;
    logic       is_store;
    logic       wr_en;
    reg_addr_t  wr_addr;

    assign opcode    = inst_i[31:26];
    assign funct     = inst_i[5:0];
    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign rd.addr_1 = inst_i[25:21];
    assign rd.addr_2 = inst_i[20:16];

    always_comb begin
        alu_op   = ALU_ADD;
        imm      = imm_sext;
        use_imm  = 1'b0;
        rd.en_1  = 1'b0;
        rd.en_2  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        wr_en    = 1'b0;
        wr_addr  = inst_i[20:16];
        case (opcode)
            OP_SPECIAL: begin
                rd.en_1 = 1'b1;
                rd.en_2 = 1'b1;
                wr_en   = 1'b1;
                wr_addr = inst_i[15:11];
                case (funct)
                    FUNCT_ADDU: alu_op = ALU_ADD;
                    FUNCT_SUBU: alu_op = ALU_SUB;
                    FUNCT_AND:  alu_op = ALU_AND;
                    FUNCT_OR:   alu_op = ALU_OR;
                    FUNCT_XOR:  alu_op = ALU_XOR;
                    FUNCT_SLT:  alu_op = ALU_SLT;
                    FUNCT_SLL:  alu_op = ALU_SLL;
                    FUNCT_SRL:  alu_op = ALU_SRL;
                    default: begin
                        rd.en_2 = 1'b0;
                        wr_en   = 1'b0;
                    end
                endcase
                // shifts take only rt
                if (!rd.en_2 || alu_op == ALU_SLL || alu_op == ALU_SRL) begin
                    rd.en_1 = 1'b0;
                end
            end
            OP_ADDIU, OP_LW: begin
                rd.en_1 = 1'b1;
                use_imm = 1'b1;
                wr_en   = 1'b1;
                is_load = (opcode == OP_LW);
            end
            OP_ANDI, OP_ORI: begin
                rd.en_1 = 1'b1;
                use_imm = 1'b1;
                wr_en   = 1'b1;
                imm     = {16'h0000, inst_i[15:0]};
                alu_op  = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
            end
            OP_LUI: begin
                use_imm = 1'b1;
                wr_en   = 1'b1;
                imm     = {inst_i[15:0], 16'h0000};
                alu_op  = ALU_LUI;
            end
            OP_SW: begin
                rd.en_1  = 1'b1;
                rd.en_2  = 1'b1;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                rd.en_1 = 1'b1;
                rd.en_2 = 1'b1;
            end
            default: ;
        endcase
    end

    // resolved on forwarded operands, one delay slot
    assign branch_taken_o = (opcode == OP_BEQ && rd.data_1 == rd.data_2) ||
                            (opcode == OP_BNE && rd.data_1 != rd.data_2);
    assign branch_target_o = inst_pc_i + 32'd4 + {imm_sext[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            is_load_o  <= 1'b0;
            is_store_o <= 1'b0;
            wr_en_o    <= 1'b0;
        end else if (!stall_i) begin
            // bubble on load-use
            is_load_o  <= is_load && !load_stall_i;
            is_store_o <= is_store && !load_stall_i;
            wr_en_o    <= wr_en && !load_stall_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            alu_op_o     <= alu_op;
            operand_a_o  <= rd.data_1;
            operand_b_o  <= use_imm ? imm : rd.data_2;
            store_data_o <= rd.data_2;
            shamt_o      <= inst_i[10:6];
            wr_addr_o    <= wr_addr;
            pc_o         <= inst_pc_i;
        end
    end
endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  stall_i,
    input  logic  hold_i,
    input  logic  branch_taken_i,
    input  addr_t branch_target_i,
    output addr_t rom_addr_o,
    input  inst_t rom_data_i,
    output inst_t inst_o,
    output addr_t inst_pc_o
);
    addr_t pc_q;

    assign rom_addr_o = pc_q;

    // an all-zero word decodes as sll r0, so reset leaves a no-op
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q   <= RESET_PC;
            inst_o <= '0;
        end else if (!(stall_i || hold_i)) begin
            pc_q   <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
            inst_o <= rom_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!(stall_i || hold_i)) begin
            inst_pc_o <= pc_q;
        end
    end
endmodule

// File: verilog/reg_read_if.sv
`timescale 1ns/1ps

interface reg_read_if
    import mips_pkg::*;
();
    logic      en_1;
    reg_addr_t addr_1;
    word_t     data_1;
    logic      en_2;
    reg_addr_t addr_2;
    word_t     data_2;

    modport decode  (output en_1, addr_1, en_2, addr_2, input data_1, data_2);
    modport bypass  (input en_1, addr_1, en_2, addr_2, output data_1, data_2);
    modport storage (input en_1, addr_1, en_2, addr_2);
endinterface

// File: verilog/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FUNCT_SLL  = 6'h00;
    localparam logic [5:0] FUNCT_SRL  = 6'h02;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;

endpackage
